// ==== leaper_movegen_pkg.sv ====
`default_nettype none

// shared board constants and types for the king and knight move generator
package leaper_movegen_pkg;

  // board geometry
  localparam int num_squares = 64;
  localparam int board_size = 8;

  // each colour collects at most this many pieces during a load
  localparam int stack_depth = 16;

  // 3-bit piece codes as they arrive on the serial position stream
  typedef logic [2:0] piece_t;

  localparam piece_t piece_none = 3'd0;
  localparam piece_t piece_king = 3'd1;
  localparam piece_t piece_queen = 3'd2;
  localparam piece_t piece_rook = 3'd3;
  localparam piece_t piece_bishop = 3'd4;
  localparam piece_t piece_knight = 3'd5;
  localparam piece_t piece_pawn = 3'd6;

  // one serial square code, the top bit set means a white piece
  typedef struct packed {
    logic white;
    piece_t piece;
  } pos_code_t;

  // index is rank times eight plus file so rank lands in the upper three bits
  typedef struct packed {
    logic [2:0] rank;
    logic [2:0] file;
  } square_rf_t;

  // the flat view feeds masks and one-hot logic, the rank/file view feeds geometry
  typedef union packed {
    logic [5:0] index;
    square_rf_t rf;
  } square_t;

  // one slot of a piece stack, full marks an occupied slot
  typedef struct packed {
    logic full;
    piece_t piece;
    square_t square;
  } stack_entry_t;

  // the 15-bit output move word
  typedef struct packed {
    piece_t piece;
    square_t from;
    square_t to;
  } move_t;

endpackage

`default_nettype wire

// ==== leaper_movegen_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// hands one piece from the move stack to the destination stage
// an item moves in a cycle where valid and take are both high
interface piece_if;
  logic valid;
  leaper_movegen_pkg::stack_entry_t entry;
  logic last;
  logic take;

  modport source(output valid, entry, last, input take);
  modport sink(input valid, entry, last, output take);
endinterface

// hands a piece with its destination mask to the arbiter
interface dest_if;
  logic valid;
  leaper_movegen_pkg::piece_t piece;
  leaper_movegen_pkg::square_t from;
  logic [leaper_movegen_pkg::num_squares-1:0] mask;
  logic last;
  logic take;

  modport source(output valid, piece, from, mask, last, input take);
  modport sink(input valid, piece, from, mask, last, output take);
endinterface

`default_nettype wire

// ==== pos_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module pos_loader (
  input  wire logic clk,
  input  wire logic i_arst_n,
  input  wire logic i_pos_valid,
  input  wire logic i_pos_sop,
  input  wire leaper_movegen_pkg::pos_code_t i_pos_data,
  output leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] o_white_stack,
  output leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] o_black_stack,
  output logic [leaper_movegen_pkg::num_squares-1:0] o_white_occ,
  output logic [leaper_movegen_pkg::num_squares-1:0] o_black_occ
);

  // square index of the next code on the serial stream
  logic [5:0] sq_cnt;
  logic [5:0] sq_idx;
  logic       pos_sop;
  logic       has_piece;
  logic       push_white;
  logic       push_black;

  leaper_movegen_pkg::stack_entry_t new_entry;
  leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] white_next;
  leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] black_next;

  // a sop code is always square a1 whatever the counter holds
  assign pos_sop = i_pos_valid && i_pos_sop;
  assign sq_idx = i_pos_sop ? 6'd0 : sq_cnt;

  assign has_piece = i_pos_data.piece != leaper_movegen_pkg::piece_none;
  assign push_white = i_pos_valid && has_piece && i_pos_data.white;
  assign push_black = i_pos_valid && has_piece && !i_pos_data.white;

  // the entry that a coloured piece pushes onto its stack
  always_comb begin
    new_entry.full = 1'b1;
    new_entry.piece = i_pos_data.piece;
    new_entry.square.index = sq_idx;
  end

  // next stack contents, a sop clears first and then the push shifts everyone down
  always_comb begin
    white_next = pos_sop ? '0 : o_white_stack;
    black_next = pos_sop ? '0 : o_black_stack;
    if (push_white) begin
      white_next = {white_next[leaper_movegen_pkg::stack_depth-2:0], new_entry};
    end
    if (push_black) begin
      black_next = {black_next[leaper_movegen_pkg::stack_depth-2:0], new_entry};
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sq_cnt <= '0;
      o_white_stack <= '0;
      o_black_stack <= '0;
      o_white_occ <= '0;
      o_black_occ <= '0;
    end else if (i_pos_valid) begin
      // wraps to zero after h8 so a stream without sop still lines up
      sq_cnt <= sq_idx + 6'd1;
      o_white_stack <= white_next;
      o_black_stack <= black_next;
      if (pos_sop) begin
        o_white_occ <= '0;
        o_black_occ <= '0;
      end
      // every square of a load is written so stale bits never survive
      o_white_occ[sq_idx] <= push_white;
      o_black_occ[sq_idx] <= push_black;
    end
  end

endmodule

`default_nettype wire

// ==== piece_iterator.sv ====
`timescale 1ns/1ps
`default_nettype none

module piece_iterator (
  input  wire logic clk,
  input  wire logic i_arst_n,
  input  wire logic i_start,
  input  wire logic i_wtp,
  input  wire leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] i_white_stack,
  input  wire leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] i_black_stack,
  piece_if.source o_piece
);

  // slot zero is the top and holds the highest square of the side to play
  leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] move_stack;
  leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] chosen;

  // a side with no pieces still sends one empty entry so the position gets its eop
  logic empty_pending;

  assign chosen = i_wtp ? i_white_stack : i_black_stack;

  assign o_piece.valid = move_stack[0].full || empty_pending;
  assign o_piece.entry = move_stack[0];
  assign o_piece.last = !move_stack[1].full;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      move_stack <= '0;
      empty_pending <= 1'b0;
    end else if (i_start) begin
      // the load stacks are left untouched so the same board can be replayed
      move_stack <= chosen;
      empty_pending <= !chosen[0].full;
    end else if (o_piece.valid && o_piece.take) begin
      // pop the top, everything moves up and an empty slot enters at the bottom
      move_stack <= move_stack >> $bits(leaper_movegen_pkg::stack_entry_t);
      empty_pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== dest_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module dest_gen (
  input  wire logic clk,
  input  wire logic i_arst_n,
  input  wire logic i_wtp,
  input  wire logic [leaper_movegen_pkg::num_squares-1:0] i_white_occ,
  input  wire logic [leaper_movegen_pkg::num_squares-1:0] i_black_occ,
  piece_if.sink   i_piece,
  dest_if.source  o_dest
);

  logic r_valid;
  logic r_last;
  leaper_movegen_pkg::piece_t  r_piece;
  leaper_movegen_pkg::square_t r_from;
  logic [leaper_movegen_pkg::num_squares-1:0] r_mask;
  logic [leaper_movegen_pkg::num_squares-1:0] own_occ;
  logic take_in;

  // every leap of a king or knight lies within two ranks and two files
  // knights need |dr|*|df| of two and kings need a step of one in any direction
  function automatic logic [leaper_movegen_pkg::num_squares-1:0] leap_mask(
    input leaper_movegen_pkg::stack_entry_t e
  );
    logic [leaper_movegen_pkg::num_squares-1:0] m;
    int dr, df, adr, adf, tr, tf;
    logic is_king, is_knight, hit;
    m = '0;
    is_king = e.full && (e.piece == leaper_movegen_pkg::piece_king);
    is_knight = e.full && (e.piece == leaper_movegen_pkg::piece_knight);
    for (dr = -2; dr <= 2; dr++) begin
      for (df = -2; df <= 2; df++) begin
        adr = (dr < 0) ? -dr : dr;
        adf = (df < 0) ? -df : df;
        hit = (is_knight && (adr * adf == 2)) ||
              (is_king && (adr <= 1) && (adf <= 1) && (adr + adf != 0));
        tr = int'(e.square.rf.rank) + dr;
        tf = int'(e.square.rf.file) + df;
        // offsets that leave the board are dropped here
        if (hit && tr >= 0 && tr < leaper_movegen_pkg::board_size &&
            tf >= 0 && tf < leaper_movegen_pkg::board_size) begin
          m[tr * leaper_movegen_pkg::board_size + tf] = 1'b1;
        end
      end
    end
    return m;
  endfunction

  // own pieces block their squares, opponent squares stay as captures
  assign own_occ = i_wtp ? i_white_occ : i_black_occ;

  // the register accepts a new piece when it is empty or being drained this cycle
  assign take_in = !r_valid || o_dest.take;
  assign i_piece.take = take_in;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= 1'b0;
    end else if (take_in) begin
      r_valid <= i_piece.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in && i_piece.valid) begin
      r_piece <= i_piece.entry.piece;
      r_from <= i_piece.entry.square;
      r_mask <= leap_mask(i_piece.entry) & ~own_occ;
      r_last <= i_piece.last;
    end
  end

  assign o_dest.valid = r_valid;
  assign o_dest.piece = r_piece;
  assign o_dest.from = r_from;
  assign o_dest.mask = r_mask;
  assign o_dest.last = r_last;

endmodule

`default_nettype wire

// ==== target_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_arbiter (
  input  wire logic clk,
  input  wire logic i_arst_n,
  dest_if.sink      i_dest,
  output logic      o_grant,
  output leaper_movegen_pkg::move_t o_move,
  output logic      o_pos_end
);

  // busy means a piece sits here with req holding its remaining destinations
  logic busy;
  logic last;
  logic done;
  logic [leaper_movegen_pkg::num_squares-1:0] req;
  logic [leaper_movegen_pkg::num_squares-1:0] grant_oh;
  leaper_movegen_pkg::piece_t  piece;
  leaper_movegen_pkg::square_t from;
  leaper_movegen_pkg::square_t to_sq;

  // the carry out of the +1 stops at the lowest set bit and isolates it
  assign grant_oh = req & (~req + 1'b1);

  // an exhausted mask spends exactly one cycle here before the next piece lands
  assign done = busy && (req == '0);
  assign i_dest.take = !busy || done;

  // one-hot back to the flat index view of the destination square
  always_comb begin
    to_sq.index = '0;
    for (int i = 0; i < leaper_movegen_pkg::num_squares; i++) begin
      if (grant_oh[i]) begin
        to_sq.index = to_sq.index | 6'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy <= 1'b0;
    end else if (i_dest.take) begin
      busy <= i_dest.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_dest.take && i_dest.valid) begin
      req <= i_dest.mask;
      piece <= i_dest.piece;
      from <= i_dest.from;
      last <= i_dest.last;
    end else if (busy) begin
      req <= req & ~grant_oh;
    end
  end

  assign o_grant = busy && (req != '0);
  assign o_pos_end = done && last;

  always_comb begin
    o_move.piece = piece;
    o_move.from = from;
    o_move.to = to_sq;
  end

endmodule

`default_nettype wire

// ==== move_emitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module move_emitter (
  input  wire logic clk,
  input  wire logic i_arst_n,
  input  wire logic i_grant,
  input  wire leaper_movegen_pkg::move_t i_move,
  input  wire logic i_pos_end,
  output logic o_move_valid,
  output leaper_movegen_pkg::move_t o_move_data,
  output logic o_move_sop,
  output logic o_move_eop
);

  // the last move is only known once the final piece is exhausted
  // so each move waits here until a later grant or the position end releases it
  logic held_valid;
  logic held_sop;
  logic sop_done;
  logic release_held;
  leaper_movegen_pkg::move_t held_move;

  assign release_held = i_grant || i_pos_end;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      held_valid <= 1'b0;
      held_sop <= 1'b0;
      sop_done <= 1'b0;
      o_move_valid <= 1'b0;
      o_move_data <= '0;
      o_move_sop <= 1'b0;
      o_move_eop <= 1'b0;
    end else begin
      o_move_valid <= release_held && held_valid;
      o_move_sop <= release_held && held_valid && held_sop;
      // eop fires even with nothing held, giving the bare eop of an empty position
      o_move_eop <= i_pos_end;
      if (release_held) begin
        o_move_data <= held_move;
      end
      if (i_grant) begin
        held_valid <= 1'b1;
        held_sop <= !sop_done;
        sop_done <= 1'b1;
      end else if (i_pos_end) begin
        held_valid <= 1'b0;
        sop_done <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_grant) begin
      held_move <= i_move;
    end
  end

endmodule

`default_nettype wire

// ==== leaper_movegen_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaper_movegen_top (
  input  wire logic clk,
  input  wire logic i_arst_n,
  input  wire logic i_pos_valid,
  input  wire logic i_pos_sop,
  input  wire leaper_movegen_pkg::pos_code_t i_pos_data,
  input  wire logic i_wtp,
  input  wire logic i_start,
  output logic o_move_valid,
  output leaper_movegen_pkg::move_t o_move_data,
  output logic o_move_sop,
  output logic o_move_eop
);

  // loader to iterator and destination stage
  leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] white_stack;
  leaper_movegen_pkg::stack_entry_t [leaper_movegen_pkg::stack_depth-1:0] black_stack;
  logic [leaper_movegen_pkg::num_squares-1:0] white_occ;
  logic [leaper_movegen_pkg::num_squares-1:0] black_occ;

  // arbiter to emitter
  logic grant;
  logic pos_end;
  leaper_movegen_pkg::move_t grant_move;

  piece_if piece_bus ();
  dest_if  dest_bus ();

  pos_loader pos_loader_i (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_pos_valid   (i_pos_valid),
    .i_pos_sop     (i_pos_sop),
    .i_pos_data    (i_pos_data),
    .o_white_stack (white_stack),
    .o_black_stack (black_stack),
    .o_white_occ   (white_occ),
    .o_black_occ   (black_occ)
  );

  piece_iterator piece_iterator_i (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_start       (i_start),
    .i_wtp         (i_wtp),
    .i_white_stack (white_stack),
    .i_black_stack (black_stack),
    .o_piece       (piece_bus.source)
  );

  dest_gen dest_gen_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_wtp       (i_wtp),
    .i_white_occ (white_occ),
    .i_black_occ (black_occ),
    .i_piece     (piece_bus.sink),
    .o_dest      (dest_bus.source)
  );

  target_arbiter target_arbiter_i (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_dest    (dest_bus.sink),
    .o_grant   (grant),
    .o_move    (grant_move),
    .o_pos_end (pos_end)
  );

  move_emitter move_emitter_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_grant      (grant),
    .i_move       (grant_move),
    .i_pos_end    (pos_end),
    .o_move_valid (o_move_valid),
    .o_move_data  (o_move_data),
    .o_move_sop   (o_move_sop),
    .o_move_eop   (o_move_eop)
  );

endmodule

`default_nettype wire

// ==== leaper_movegen_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaper_movegen_assert (
  input wire logic clk,
  input wire logic i_arst_n,
  input wire logic i_start,
  input wire logic i_move_valid,
  input wire logic i_move_sop,
  input wire logic i_move_eop
);

  // high from a start until the eop that closes its position
  logic armed;

  // set once the first move of a position has left the outputs
  logic moved;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      armed <= 1'b0;
    end else if (i_start) begin
      armed <= 1'b1;
    end else if (i_move_eop) begin
      armed <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      moved <= 1'b0;
    end else if (i_start) begin
      moved <= 1'b0;
    end else if (i_move_valid) begin
      moved <= 1'b1;
    end
  end

  // sop belongs to a valid move and only to the first one after a start
  sop_needs_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_move_sop |-> i_move_valid && !moved)
    else $error("sop seen without a valid move or after the first move");

  valid_needs_start: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_move_valid |-> armed)
    else $error("move output without a start since the last eop");

  // reset is asynchronous so the outputs are already low at the first edge
  quiet_in_reset: assert property (@(posedge clk)
    !i_arst_n |-> !(i_move_valid || i_move_sop || i_move_eop))
    else $error("output activity while reset is asserted");

endmodule

bind leaper_movegen_top leaper_movegen_assert leaper_movegen_assert_i (
  .clk          (clk),
  .i_arst_n     (i_arst_n),
  .i_start      (i_start),
  .i_move_valid (o_move_valid),
  .i_move_sop   (o_move_sop),
  .i_move_eop   (o_move_eop)
);

`default_nettype wire

// ==== tb_leaper_movegen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_leaper_movegen;

  localparam int half_period = 10;
  localparam int drive_delay = 2;
  localparam int gap_max = 8;
  localparam int mem_words = 256;

  logic clk;
  logic i_arst_n;
  logic i_pos_valid;
  logic i_pos_sop;
  leaper_movegen_pkg::pos_code_t i_pos_data;
  logic i_wtp;
  logic i_start;
  logic o_move_valid;
  leaper_movegen_pkg::move_t o_move_data;
  logic o_move_sop;
  logic o_move_eop;

  // raw words of the golden file, rd walks through them record by record
  logic [15:0] golden [0:mem_words-1];
  leaper_movegen_pkg::pos_code_t board [0:leaper_movegen_pkg::num_squares-1];
  leaper_movegen_pkg::move_t expected [$];

  int seed = 64;
  int rd;
  int num_pos;
  int move_errors;
  int flag_errors;
  int count_errors;

  leaper_movegen_top dut_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_pos_valid  (i_pos_valid),
    .i_pos_sop    (i_pos_sop),
    .i_pos_data   (i_pos_data),
    .i_wtp        (i_wtp),
    .i_start      (i_start),
    .o_move_valid (o_move_valid),
    .o_move_data  (o_move_data),
    .o_move_sop   (o_move_sop),
    .o_move_eop   (o_move_eop)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  task automatic check_move(input leaper_movegen_pkg::move_t got,
                            input leaper_movegen_pkg::move_t exp, input string what);
    if (got !== exp) begin
      move_errors++;
      $display("FAILED t=%0t %s: got piece %0d %0d->%0d, expected piece %0d %0d->%0d",
               $time, what, got.piece, got.from.index, got.to.index,
               exp.piece, exp.from.index, exp.to.index);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("FAILED t=%0t %s: got %b expected %b", $time, what, got, exp);
    end
  endtask

  // builds the board from the record and streams all 64 squares, a1 first
  task automatic load_position(input int n);
    int k;
    int sq;
    logic [15:0] w;
    for (sq = 0; sq < leaper_movegen_pkg::num_squares; sq++) begin
      board[sq] = '0;
    end
    for (k = 0; k < n; k++) begin
      w = golden[rd];
      rd++;
      board[w[9:4]] = w[3:0];
    end
    for (sq = 0; sq < leaper_movegen_pkg::num_squares; sq++) begin
      @(posedge clk);
      #drive_delay;
      i_pos_valid = 1'b1;
      i_pos_sop = (sq == 0);
      i_pos_data = board[sq];
    end
    @(posedge clk);
    #drive_delay;
    i_pos_valid = 1'b0;
    i_pos_sop = 1'b0;
    i_pos_data = '0;
  endtask

  // pulses start and follows the move stream up to its eop cycle
  task automatic run_position(input logic wtp, input int m, input int pos);
    int k;
    int got_cnt;
    bit seen_eop;
    expected.delete();
    for (k = 0; k < m; k++) begin
      expected.push_back(golden[rd][14:0]);
      rd++;
    end
    @(posedge clk);
    #drive_delay;
    i_wtp = wtp;
    i_start = 1'b1;
    @(posedge clk);
    #drive_delay;
    i_start = 1'b0;
    got_cnt = 0;
    seen_eop = 1'b0;
    // outputs are registered so the falling edge sees them settled
    while (!seen_eop) begin
      @(negedge clk);
      if (o_move_valid) begin
        if (got_cnt < m) begin
          check_move(o_move_data, expected[got_cnt],
                     $sformatf("position %0d move %0d", pos, got_cnt));
          check_flag(o_move_sop, got_cnt == 0, $sformatf("position %0d sop", pos));
          check_flag(o_move_eop, got_cnt == m - 1, $sformatf("position %0d eop", pos));
        end else begin
          count_errors++;
          $display("FAILED t=%0t position %0d: extra move beyond %0d", $time, pos, m);
        end
        got_cnt++;
      end else begin
        check_flag(o_move_sop, 1'b0, $sformatf("position %0d sop without move", pos));
        // a bare eop is only right when the position has no moves at all
        if (m != 0) begin
          check_flag(o_move_eop, 1'b0, $sformatf("position %0d bare eop", pos));
        end
      end
      seen_eop = o_move_eop;
    end
    if (got_cnt != m) begin
      count_errors++;
      $display("FAILED t=%0t position %0d: got %0d moves expected %0d",
               $time, pos, got_cnt, m);
    end
  endtask

  initial begin
    int p;
    int gap;
    int n_pieces;
    int n_moves;
    logic wtp;
    i_arst_n = 1'b0;
    i_pos_valid = 1'b0;
    i_pos_sop = 1'b0;
    i_pos_data = '0;
    i_wtp = 1'b0;
    i_start = 1'b0;
    move_errors = 0;
    flag_errors = 0;
    count_errors = 0;
    $readmemh("leaper_movegen_golden.txt", golden);
    num_pos = golden[0];
    rd = 1;
    repeat (4) @(posedge clk);
    #drive_delay;
    i_arst_n = 1'b1;
    for (p = 0; p < num_pos; p++) begin
      gap = $random(seed) & 7;
      repeat (gap) @(posedge clk);
      wtp = golden[rd][0];
      n_pieces = golden[rd + 1];
      n_moves = golden[rd + 2];
      rd += 3;
      load_position(n_pieces);
      run_position(wtp, n_moves, p);
    end
    repeat (4) @(posedge clk);
    $display("errors: move %0d flag %0d count %0d", move_errors, flag_errors, count_errors);
    if (move_errors + flag_errors + count_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // each position needs a load, a start and at most the worst case stream
  initial begin
    int limit;
    #1;
    limit = num_pos * (64 + 4 + leaper_movegen_pkg::stack_depth * 10 + gap_max + 4) + 100;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== leaper_movegen_golden.txt ====
// first word: number of positions; each record: side to play (1 white), pieces, moves
// then pieces as square*16+code and moves as piece*4096+from*64+to, all hex
8
// lone white knight in the a1 corner
1 1 2  00d  500a 5011
// lone white knight on d4
1 1 8  1bd  56ca 56cc 56d1 56d5 56e1 56e5 56ea 56ec
// lone white king on e1
1 1 5  049  1103 1105 110b 110c 110d
// king on e1 with own rook d2 and pawn f1, black knight e2 and bishop d1
1 5 3  049 0bb 05e 0c5 034  1103 110c 110d
// black knights g8 b8, king e8, pawn d7 against a white king on e1
0 5 9  3e5 3c1 395 336 049  5fad 5faf 5fb4 1f34 1f35 1f3b 1f3d 5e68 5e6a
// white king boxed in on a1 by its own pawns
1 4 0  009 01e 08e 09e
// the same board as the black to play record, now white to play
1 5 5  3e5 3c1 395 336 049  1103 1105 110b 110c 110d
// black to play with no black pieces on the board
0 1 0  00d

// ==== leaper_movegen.f ====
leaper_movegen_pkg.sv
leaper_movegen_if.sv
pos_loader.sv
piece_iterator.sv
dest_gen.sv
target_arbiter.sv
move_emitter.sv
leaper_movegen_top.sv
leaper_movegen_assert.sv
tb_leaper_movegen.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
  --top-module tb_leaper_movegen -f leaper_movegen.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -qx "PASS: all tests" sim.log; then
  exit 0
fi
echo "simulation did not pass"
exit 1
